//--- verilog/axi_slave_pkg.sv
package axi_slave_pkg;

    //////////////////////////////
    // widths and codes

    localparam int addr_w    = 32;          // axi address width
    localparam int id_w      = 4;
    localparam int len_w     = 4;           // axi3 burst length field
    localparam int size_w    = 3;
    localparam int data_w    = 32;
    localparam int strb_w    = 4;
    localparam int mem_bytes = 128;
    localparam int mem_aw    = 7;           // byte index into the memory

    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr  = 2'b01;
    localparam logic [1:0] burst_wrap  = 2'b10;

    localparam logic [1:0] resp_okay   = 2'b00;

    //////////////////////////////
    // beat word, seen whole or per lane

    typedef union packed {
        logic [data_w-1:0]         word;
        logic [strb_w-1:0][7:0]    bytes;   // bytes[0] is lane 0, bits 7:0
    } beat_word_t;

    //////////////////////////////
    // address rules

    // wrap boundary in bytes = beats * bytes per beat
    function automatic logic [7:0] wrap_boundary(input logic [len_w-1:0]  len,
                                                 input logic [size_w-1:0] size);
        logic [7:0] beats;
        beats = 8'(len) + 8'd1;
        return beats << size;
    endfunction

    // next address after a step of some bytes under the burst rule
    function automatic logic [addr_w-1:0] step_addr(input logic [addr_w-1:0] addr,
                                                    input logic [3:0]        step,
                                                    input logic [1:0]        burst,
                                                    input logic [7:0]        boundary);
        logic [addr_w-1:0] nxt;
        logic [addr_w-1:0] mask;
        nxt  = addr + addr_w'(step);
        mask = addr_w'(boundary) - 1'b1;    // boundary is a power of two
        if (burst == burst_fixed || step == 4'd0)
            return addr;
        if (burst == burst_wrap && boundary != 8'd0 && (nxt & mask) == '0)
            nxt = nxt - addr_w'(boundary);  // fold back to the wrap base
        return nxt;
    endfunction

endpackage

//--- verilog/axi_burst_if.sv
`timescale 1ns/100ps

// one accepted burst, handed from the address stage to a data stage
interface axi_burst_if
    import axi_slave_pkg::*;
();

    logic                valid;     // a burst is buffered
    logic                take;      // last beat done, frees the buffer
    logic [addr_w-1:0]   addr;
    logic [len_w-1:0]    len;
    logic [size_w-1:0]   size;
    logic [1:0]          burst;
    logic [id_w-1:0]     id;

    modport src (
        output valid,
        output addr,
        output len,
        output size,
        output burst,
        output id,
        input  take
    );

    modport dst (
        input  valid,
        input  addr,
        input  len,
        input  size,
        input  burst,
        input  id,
        output take
    );

endinterface

//--- verilog/axi_addr_stage.sv
`timescale 1ns/100ps

module axi_addr_stage
    import axi_slave_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic [id_w-1:0]     req_id,
    input  logic [addr_w-1:0]   req_addr,
    input  logic [len_w-1:0]    req_len,
    input  logic [size_w-1:0]   req_size,
    input  logic [1:0]          req_burst,
    axi_burst_if.src            burst
);

    typedef enum logic [1:0] {
        st_idle  = 2'b00,       // buffer empty, waiting for a request
        st_ready = 2'b01,       // ready pulse, request taken at the next edge
        st_full  = 2'b10        // burst held until the data stage takes it
    } state_t;

    state_t state, state_nxt;

    logic [id_w-1:0]    id_q;
    logic [addr_w-1:0]  addr_q;
    logic [len_w-1:0]   len_q;
    logic [size_w-1:0]  size_q;
    logic [1:0]         burst_q;

    //////////////////////////////
    // request FSM

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:  if (req_valid) state_nxt = st_ready;
            st_ready: state_nxt = req_valid ? st_full : st_idle;   // master holds valid
            st_full:  if (burst.take) state_nxt = st_idle;
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign req_ready = (state == st_ready);

    //////////////////////////////
    // one-entry request buffer

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            id_q    <= req_id;
            addr_q  <= req_addr;
            len_q   <= req_len;
            size_q  <= req_size;
            burst_q <= req_burst;
        end
    end

    assign burst.valid = (state == st_full);
    assign burst.id    = id_q;
    assign burst.addr  = addr_q;
    assign burst.len   = len_q;
    assign burst.size  = size_q;
    assign burst.burst = burst_q;

    // wrap only for 2, 4, 8 or 16 beats of at most 4 bytes
    a_wrap_legal: assert property (@(posedge clk) disable iff (!resetn)
        req_valid && req_ready && req_burst == burst_wrap |->
            (req_len inside {4'd1, 4'd3, 4'd7, 4'd15}) && req_size <= 3'd2);

    // master keeps valid up through the ready pulse
    a_valid_held: assert property (@(posedge clk) disable iff (!resetn)
        req_ready |-> req_valid);

endmodule

//--- verilog/axi_write_stage.sv
`timescale 1ns/100ps

module axi_write_stage
    import axi_slave_pkg::*;
(
    input  logic                          clk,
    input  logic                          resetn,
    axi_burst_if.dst                      burst,
    input  logic                          wvalid,
    output logic                          wready,
    input  beat_word_t                    wdata,
    input  logic [strb_w-1:0]             wstrb,
    input  logic                          wlast,
    input  logic                          bready,
    output logic                          bvalid,
    output logic [id_w-1:0]               bid,
    output logic [1:0]                    bresp,
    output logic [strb_w-1:0]             mem_we,
    output logic [strb_w-1:0][mem_aw-1:0] mem_waddr,
    output logic [strb_w-1:0][7:0]        mem_wbyte
);

    logic               hs;             // beat handshake
    logic               first;          // next beat is the first of a burst
    logic [len_w-1:0]   beat_cnt;
    logic [addr_w-1:0]  beat_addr;
    logic [addr_w-1:0]  cur_addr;
    logic [addr_w-1:0]  lane_end;
    logic [addr_w-1:0]  next_addr;
    logic [1:0]         lane_burst;
    logic [7:0]         boundary;

    assign hs         = wvalid && wready;
    assign boundary   = wrap_boundary(burst.len, burst.size);
    assign cur_addr   = first ? burst.addr : beat_addr;

    // inside a beat the bytes are always consecutive, wrap still folds
    assign lane_burst = (burst.burst == burst_wrap) ? burst_wrap : burst_incr;

    //////////////////////////////
    // byte packing

    // each set lane takes the next address, clear lanes take no step
    always_comb begin
        lane_end = cur_addr;
        for (int i = 0; i < strb_w; i++) begin
            mem_waddr[i] = lane_end[mem_aw-1:0];
            lane_end     = step_addr(lane_end, {3'b000, wstrb[i]}, lane_burst, boundary);
        end
    end

    assign next_addr  = (burst.burst == burst_fixed) ? cur_addr : lane_end;
    assign mem_we     = hs ? wstrb : '0;
    assign mem_wbyte  = wdata.bytes;
    assign burst.take = hs && wlast;
    assign bresp      = resp_okay;

    //////////////////////////////
    // beat and response control

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            first    <= 1'b1;
            beat_cnt <= '0;
        end else begin
            wready <= burst.valid && wvalid && !wready && !bvalid;  // one-cycle pulse
            if (hs) begin
                first    <= wlast;
                beat_cnt <= wlast ? '0 : beat_cnt + 1'b1;
            end
            if (hs && wlast)
                bvalid <= 1'b1;
            else if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hs)
            beat_addr <= next_addr;
        if (hs && wlast)
            bid <= burst.id;        // response id of the finished burst
    end

    a_strb_set: assert property (@(posedge clk) disable iff (!resetn)
        hs |-> wstrb != '0);

    // wlast must land on beat len+1 of the buffered burst
    a_wlast_cnt: assert property (@(posedge clk) disable iff (!resetn)
        hs |-> (wlast == (beat_cnt == burst.len)));

endmodule

//--- verilog/axi_read_stage.sv
`timescale 1ns/100ps

module axi_read_stage
    import axi_slave_pkg::*;
(
    input  logic                          clk,
    input  logic                          resetn,
    axi_burst_if.dst                      burst,
    output logic [strb_w-1:0][mem_aw-1:0] mem_raddr,
    input  logic [strb_w-1:0][7:0]        mem_rbyte,
    input  logic                          rready,
    output logic                          rvalid,
    output logic [id_w-1:0]               rid,
    output beat_word_t                    rdata,
    output logic [1:0]                    rresp,
    output logic                          rlast
);

    logic               hs;
    logic               load;           // present a new beat at this edge
    logic [len_w-1:0]   beat_cnt;
    logic [len_w-1:0]   ld_cnt;
    logic [addr_w-1:0]  next_q;         // start address of the following beat
    logic [addr_w-1:0]  ld_addr;
    logic [addr_w-1:0]  lane_end;
    logic [strb_w-1:0]  lane_on;        // lanes inside the beat size
    logic [1:0]         lane_burst;
    logic [7:0]         boundary;
    beat_word_t         rd_beat;

    assign hs         = rvalid && rready;
    assign load       = (burst.valid && !rvalid) || (hs && !rlast);
    assign ld_addr    = rvalid ? next_q : burst.addr;
    assign ld_cnt     = rvalid ? beat_cnt + 1'b1 : '0;
    assign boundary   = wrap_boundary(burst.len, burst.size);
    assign lane_burst = (burst.burst == burst_wrap) ? burst_wrap : burst_incr;

    always_comb begin
        case (burst.size)
            3'd0:    lane_on = 4'b0001;
            3'd1:    lane_on = 4'b0011;
            default: lane_on = 4'b1111;
        endcase
    end

    //////////////////////////////
    // lane addresses and data

    always_comb begin
        lane_end = ld_addr;
        for (int i = 0; i < strb_w; i++) begin
            mem_raddr[i]  = lane_end[mem_aw-1:0];
            rd_beat.bytes[i] = lane_on[i] ? mem_rbyte[i] : 8'h00;  // upper lanes zero
            lane_end      = step_addr(lane_end, {3'b000, lane_on[i]}, lane_burst, boundary);
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            beat_cnt <= '0;
        end else if (load) begin
            rvalid   <= 1'b1;
            rlast    <= (ld_cnt == burst.len);
            beat_cnt <= ld_cnt;
        end else if (hs) begin
            rvalid   <= 1'b0;   // last beat gone
            rlast    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            next_q <= (burst.burst == burst_fixed) ? ld_addr : lane_end;
            rid    <= burst.id;
            rdata  <= rd_beat;
        end
    end

    assign rresp      = resp_okay;
    assign burst.take = hs && rlast;

    a_rdata_hold: assert property (@(posedge clk) disable iff (!resetn)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- verilog/axi_byte_mem.sv
`timescale 1ns/100ps

module axi_byte_mem
    import axi_slave_pkg::*;
(
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [strb_w-1:0]             we,
    input  logic [strb_w-1:0][mem_aw-1:0] waddr,
    input  logic [strb_w-1:0][7:0]        wbyte,
    input  logic [strb_w-1:0][mem_aw-1:0] raddr,
    output logic [strb_w-1:0][7:0]        rbyte
);

    logic [7:0] mem [mem_bytes];

    // lanes written in order, a higher lane wins on the same byte
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < mem_bytes; i++)
                mem[i] <= 8'h00;
        end else begin
            for (int l = 0; l < strb_w; l++) begin
                if (we[l])
                    mem[waddr[l]] <= wbyte[l];
            end
        end
    end

    // read lanes are combinational
    always_comb begin
        for (int l = 0; l < strb_w; l++)
            rbyte[l] = mem[raddr[l]];
    end

endmodule

//--- verilog/axi_slave_top.sv
`timescale 1ns/100ps

module axi_slave_top
    import axi_slave_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,

    input  logic                awvalid,    // write address channel
    output logic                awready,
    input  logic [id_w-1:0]     awid,
    input  logic [len_w-1:0]    awlen,
    input  logic [size_w-1:0]   awsize,
    input  logic [addr_w-1:0]   awaddr,
    input  logic [1:0]          awburst,

    input  logic                wvalid,     // write data channel
    output logic                wready,
    input  logic [data_w-1:0]   wdata,
    input  logic [strb_w-1:0]   wstrb,
    input  logic                wlast,

    input  logic                bready,     // write response channel
    output logic                bvalid,
    output logic [id_w-1:0]     bid,
    output logic [1:0]          bresp,

    input  logic                arvalid,    // read address channel
    output logic                arready,
    input  logic [id_w-1:0]     arid,
    input  logic [len_w-1:0]    arlen,
    input  logic [size_w-1:0]   arsize,
    input  logic [addr_w-1:0]   araddr,
    input  logic [1:0]          arburst,

    output logic                rvalid,     // read data channel
    input  logic                rready,
    output logic [id_w-1:0]     rid,
    output logic [data_w-1:0]   rdata,
    output logic [1:0]          rresp,
    output logic                rlast
);

    axi_burst_if w_burst ();
    axi_burst_if r_burst ();

    beat_word_t                    wbeat;
    beat_word_t                    rbeat;
    logic [strb_w-1:0]             mem_we;
    logic [strb_w-1:0][mem_aw-1:0] mem_waddr;
    logic [strb_w-1:0][7:0]        mem_wbyte;
    logic [strb_w-1:0][mem_aw-1:0] mem_raddr;
    logic [strb_w-1:0][7:0]        mem_rbyte;

    assign wbeat.word = wdata;
    assign rdata      = rbeat.word;

    //////////////////////////////
    // write path

    axi_addr_stage u_aw (
        .clk(clk), .resetn(resetn),
        .req_valid(awvalid), .req_ready(awready), .req_id(awid), .req_addr(awaddr),
        .req_len(awlen), .req_size(awsize), .req_burst(awburst), .burst(w_burst.src)
    );

    axi_write_stage u_wr (
        .clk(clk), .resetn(resetn), .burst(w_burst.dst),
        .wvalid(wvalid), .wready(wready), .wdata(wbeat), .wstrb(wstrb), .wlast(wlast),
        .bready(bready), .bvalid(bvalid), .bid(bid), .bresp(bresp),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wbyte(mem_wbyte)
    );

    //////////////////////////////
    // read path

    axi_addr_stage u_ar (
        .clk(clk), .resetn(resetn),
        .req_valid(arvalid), .req_ready(arready), .req_id(arid), .req_addr(araddr),
        .req_len(arlen), .req_size(arsize), .req_burst(arburst), .burst(r_burst.src)
    );

    axi_read_stage u_rd (
        .clk(clk), .resetn(resetn), .burst(r_burst.dst),
        .mem_raddr(mem_raddr), .mem_rbyte(mem_rbyte),
        .rready(rready), .rvalid(rvalid), .rid(rid), .rdata(rbeat),
        .rresp(rresp), .rlast(rlast)
    );

    axi_byte_mem u_mem (
        .clk(clk), .resetn(resetn),
        .we(mem_we), .waddr(mem_waddr), .wbyte(mem_wbyte),
        .raddr(mem_raddr), .rbyte(mem_rbyte)
    );

endmodule

//--- dv/axi_checker.sv
`timescale 1ns/100ps

module axi_checker
    import axi_slave_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                awvalid, awready,
    input  logic [id_w-1:0]     awid,
    input  logic [addr_w-1:0]   awaddr,
    input  logic [len_w-1:0]    awlen,
    input  logic [size_w-1:0]   awsize,
    input  logic [1:0]          awburst,
    input  logic                wvalid, wready, wlast,
    input  logic [data_w-1:0]   wdata,
    input  logic [strb_w-1:0]   wstrb,
    input  logic                bvalid, bready,
    input  logic [id_w-1:0]     bid,
    input  logic [1:0]          bresp,
    input  logic                arvalid, arready,
    input  logic [id_w-1:0]     arid,
    input  logic [addr_w-1:0]   araddr,
    input  logic [len_w-1:0]    arlen,
    input  logic [size_w-1:0]   arsize,
    input  logic [1:0]          arburst,
    input  logic                rvalid, rready, rlast,
    input  logic [id_w-1:0]     rid,
    input  logic [data_w-1:0]   rdata,
    input  logic [1:0]          rresp,
    output int                  checks,
    output int                  errors
);

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
        logic [size_w-1:0] size;
        logic [1:0]        burst;
    } req_t;

    logic [7:0]        model [mem_bytes];
    req_t              aw_q [$];
    req_t              ar_q [$];
    logic [id_w-1:0]   bid_q [$];           // ids of finished write bursts
    logic [addr_w-1:0] w_addr;
    logic [addr_w-1:0] r_addr;
    logic              w_first;
    logic [len_w-1:0]  r_beat;
    logic              b_due;               // bvalid expected at this edge
    logic              b_held;
    logic              r_held;
    logic              awready_prev;
    logic              wready_prev;
    logic              arready_prev;
    logic [id_w-1:0]   bid_prev;
    logic [id_w-1:0]   rid_prev;
    logic [data_w-1:0] rdata_prev;

    //////////////////////////////
    // reference model

    // byte after a, a wrap burst falls back one window at each window multiple
    function automatic logic [addr_w-1:0] next_byte(input req_t rq, input logic [addr_w-1:0] a);
        int span;
        span = (rq.len + 1) * (1 << rq.size);
        if (rq.burst == burst_wrap && (a + 1) % span == 0)
            return a + 1 - span;
        return a + 1;
    endfunction

    function automatic logic [addr_w-1:0] advance(input req_t rq, input logic [addr_w-1:0] a,
                                                  input int n);
        if (rq.burst == burst_fixed)
            return a;                       // every beat restarts here
        for (int i = 0; i < n; i++)
            a = next_byte(rq, a);
        return a;
    endfunction

    function automatic beat_word_t expect_beat(input req_t rq, input logic [addr_w-1:0] a);
        beat_word_t bw;
        bw.word = '0;                       // lanes above the size stay zero
        for (int i = 0; i < (1 << rq.size) && i < strb_w; i++) begin
            bw.bytes[i] = model[a[mem_aw-1:0]];
            a = next_byte(rq, a);
        end
        return bw;
    endfunction

    task automatic check_val(input string name, input logic [31:0] expv, input logic [31:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("ERR %s expected %h got %h", name, expv, actv);
        end
    endtask

    //////////////////////////////
    // comparisons

    always @(posedge clk or negedge resetn) begin
        req_t              rq;
        logic [addr_w-1:0] a;
        beat_word_t        wb;
        beat_word_t        exp;
        if (!resetn) begin
            for (int i = 0; i < mem_bytes; i++)
                model[i] = 8'h00;
            aw_q.delete();
            ar_q.delete();
            bid_q.delete();
            w_first      = 1'b1;
            r_beat       = '0;
            b_due        = 1'b0;
            b_held       = 1'b0;
            r_held       = 1'b0;
            awready_prev = 1'b0;
            wready_prev  = 1'b0;
            arready_prev = 1'b0;
            checks       = 0;
            errors       = 0;
        end else begin
            if (b_held) begin                       // response held under back-pressure
                check_val("bvalid", 1, bvalid);
                check_val("bid", bid_prev, bid);
            end
            if (r_held) begin
                check_val("rvalid", 1, rvalid);
                check_val("rid", rid_prev, rid);
                check_val("rdata", rdata_prev, rdata);
            end
            if (b_due)
                check_val("bvalid", 1, bvalid);
            b_due = 1'b0;

            // every ready is a single-cycle pulse
            if (awready_prev)
                check_val("awready", 0, awready);
            if (wready_prev)
                check_val("wready", 0, wready);
            if (arready_prev)
                check_val("arready", 0, arready);

            if (awvalid && awready)
                aw_q.push_back(req_t'{awid, awaddr, awlen, awsize, awburst});
            if (arvalid && arready)
                ar_q.push_back(req_t'{arid, araddr, arlen, arsize, arburst});

            if (wvalid && wready) begin
                if (aw_q.size() == 0) begin
                    errors++;
                    $display("write beat accepted with no write burst open");
                end else begin
                    rq      = aw_q[0];
                    wb.word = wdata;
                    w_addr  = w_first ? rq.addr : w_addr;
                    a       = w_addr;
                    for (int i = 0; i < strb_w; i++) begin
                        if (wstrb[i]) begin
                            model[a[mem_aw-1:0]] = wb.bytes[i];
                            a = next_byte(rq, a);
                        end
                    end
                    w_addr  = advance(rq, w_addr, $countones(wstrb));
                    w_first = wlast;
                    if (wlast) begin
                        bid_q.push_back(rq.id);
                        void'(aw_q.pop_front());
                        b_due = 1'b1;
                    end
                end
            end

            if (bvalid && bready) begin
                if (bid_q.size() == 0) begin
                    errors++;
                    $display("write response seen with no finished write burst");
                end else begin
                    check_val("bid", bid_q.pop_front(), bid);
                end
                check_val("bresp", resp_okay, bresp);
            end

            if (rvalid && rready) begin
                if (ar_q.size() == 0) begin
                    errors++;
                    $display("read beat seen with no read burst open");
                end else begin
                    rq  = ar_q[0];
                    a   = (r_beat == 0) ? rq.addr : r_addr;
                    exp = expect_beat(rq, a);
                    check_val("rdata", exp.word, rdata);
                    check_val("rid", rq.id, rid);
                    check_val("rlast", r_beat == rq.len, rlast);
                    check_val("rresp", resp_okay, rresp);
                    r_addr = advance(rq, a, 1 << rq.size);
                    if (r_beat == rq.len) begin
                        r_beat = '0;
                        void'(ar_q.pop_front());
                    end else begin
                        r_beat = r_beat + 1'b1;
                    end
                end
            end

            b_held       = bvalid && !bready;
            bid_prev     = bid;
            r_held       = rvalid && !rready;
            rid_prev     = rid;
            rdata_prev   = rdata;
            awready_prev = awready;
            wready_prev  = wready;
            arready_prev = arready;
        end
    end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/100ps

module tb_top
    import axi_slave_pkg::*;
();

    localparam int wait_limit = 200;        // cycles allowed for any one wait

    logic                clk;
    logic                resetn = 1'b0;
    logic                awvalid = 1'b0;
    logic                awready;
    logic [id_w-1:0]     awid = '0;
    logic [addr_w-1:0]   awaddr = '0;
    logic [len_w-1:0]    awlen = '0;
    logic [size_w-1:0]   awsize = '0;
    logic [1:0]          awburst = '0;
    logic                wvalid = 1'b0;
    logic                wready;
    logic [data_w-1:0]   wdata = '0;
    logic [strb_w-1:0]   wstrb = '0;
    logic                wlast = 1'b0;
    logic                bready = 1'b0;
    logic                bvalid;
    logic [id_w-1:0]     bid;
    logic [1:0]          bresp;
    logic                arvalid = 1'b0;
    logic                arready;
    logic [id_w-1:0]     arid = '0;
    logic [addr_w-1:0]   araddr = '0;
    logic [len_w-1:0]    arlen = '0;
    logic [size_w-1:0]   arsize = '0;
    logic [1:0]          arburst = '0;
    logic                rvalid;
    logic                rready = 1'b0;
    logic [id_w-1:0]     rid;
    logic [data_w-1:0]   rdata;
    logic [1:0]          rresp;
    logic                rlast;

    int seed = 32'he7bd;
    int drv_fails = 0;                      // timeouts and lost beats
    int checks;
    int errors;

    axi_slave_top u_dut (.*);
    axi_checker   u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // master driver

    task automatic report_stall(input string what);
        $display("timeout: %s", what);
        drv_fails++;
    endtask

    task automatic end_test(input string name);
        $display("test %s done, check errors %0d, driver failures %0d", name, errors, drv_fails);
    endtask

    task automatic send_aw(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                           input logic [len_w-1:0] len, input logic [size_w-1:0] size,
                           input logic [1:0] bt);
        bit got;
        got     = 1'b0;
        awvalid = 1'b1;
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awsize  = size;
        awburst = bt;
        for (int n = 0; n < wait_limit && !got; n++) begin
            @(posedge clk);
            got = awready;                  // transfer at this edge
        end
        #2;
        awvalid = 1'b0;
        if (!got)
            report_stall("awready never rose for the write request");
    endtask

    task automatic send_ar(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                           input logic [len_w-1:0] len, input logic [size_w-1:0] size,
                           input logic [1:0] bt);
        bit got;
        got     = 1'b0;
        arvalid = 1'b1;
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arsize  = size;
        arburst = bt;
        for (int n = 0; n < wait_limit && !got; n++) begin
            @(posedge clk);
            got = arready;
        end
        #2;
        arvalid = 1'b0;
        if (!got)
            report_stall("arready never rose for the read request");
    endtask

    // mode 0 full strobes, 1 random strobes, 2 low lanes of the beat size
    task automatic send_wbeats(input logic [len_w-1:0] len, input logic [size_w-1:0] size,
                               input int mode);
        bit got;
        for (int b = 0; b <= len; b++) begin
            wvalid = 1'b1;
            wdata  = $random(seed);
            wlast  = (b == len);
            if (mode == 0) begin
                wstrb = 4'hf;
            end else if (mode == 1) begin
                wstrb = 4'($random(seed));
                if (wstrb == 4'h0)
                    wstrb = 4'h8;
            end else begin
                wstrb = (size == 3'd0) ? 4'h1 : (size == 3'd1) ? 4'h3 : 4'hf;
            end
            got = 1'b0;
            for (int n = 0; n < wait_limit && !got; n++) begin
                @(posedge clk);
                got = wready;
            end
            #2;
            if (!got) begin
                report_stall("wready never rose for a write beat");
                break;
            end
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic take_bresp(input int stall);
        bit got;
        got    = 1'b0;
        bready = 1'b0;
        for (int n = 0; n < wait_limit && !got; n++) begin
            @(posedge clk);
            got = bvalid;
        end
        #2;
        if (!got) begin
            report_stall("bvalid never rose after wlast");
        end else begin
            repeat (stall) begin
                @(posedge clk);             // response held back
                #2;
            end
            bready = 1'b1;
            got    = 1'b0;
            for (int n = 0; n < wait_limit && !got; n++) begin
                @(posedge clk);
                got = bvalid;
            end
            #2;
            bready = 1'b0;
            if (!got)
                report_stall("bvalid dropped before bready");
        end
    endtask

    task automatic take_rbeats(input logic [len_w-1:0] len, input bit stall_on);
        int beats;
        bit done;
        beats  = 0;
        done   = 1'b0;
        rready = stall_on ? (($random(seed) & 3) != 0) : 1'b1;
        for (int n = 0; n < wait_limit && !done; n++) begin
            @(posedge clk);
            if (rvalid && rready) begin
                beats++;
                done = rlast;
            end
            #2;
            rready = stall_on ? (($random(seed) & 3) != 0) : 1'b1;
        end
        rready = 1'b0;
        if (!done) begin
            report_stall("rlast never seen on the read data channel");
        end else if (beats != len + 1) begin
            $display("read burst returned %0d beats instead of %0d", beats, len + 1);
            drv_fails++;
        end
    endtask

    task automatic write_burst(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                               input logic [len_w-1:0] len, input logic [size_w-1:0] size,
                               input logic [1:0] bt, input int mode, input int stall);
        send_aw(id, addr, len, size, bt);
        send_wbeats(len, size, mode);
        take_bresp(stall);
    endtask

    task automatic read_burst(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
                              input logic [len_w-1:0] len, input logic [size_w-1:0] size,
                              input logic [1:0] bt, input bit stall_on);
        send_ar(id, addr, len, size, bt);
        take_rbeats(len, stall_on);
    endtask

    //////////////////////////////
    // test sequence

    initial begin
        logic [len_w-1:0]  len;
        logic [7:0]        bnd;
        logic [addr_w-1:0] start;
        repeat (16) @(posedge clk);
        #2;
        resetn = 1'b1;

        write_burst(4'h1, 32'h00, 4'd3, 3'd2, burst_incr, 0, 0);
        write_burst(4'h2, 32'h10, 4'd3, 3'd2, burst_incr, 1, 0);
        read_burst(4'h3, 32'h00, 4'd3, 3'd2, burst_incr, 1'b0);
        read_burst(4'h4, 32'h10, 4'd3, 3'd2, burst_incr, 1'b0);
        end_test("incr");

        write_burst(4'h5, 32'h30, 4'd3, 3'd2, burst_fixed, 1, 0);
        read_burst(4'h6, 32'h30, 4'd0, 3'd2, burst_fixed, 1'b0);
        end_test("fixed");

        for (int l = 0; l < 4; l++) begin
            for (int s = 0; s < 3; s++) begin
                len   = 4'((2 << l) - 1);
                bnd   = 8'((2 << l) << s);
                start = 32'h40 + 32'(bnd / 2);     // halfway into the wrap window
                write_burst(4'(l * 3 + s), start, len, 3'(s), burst_wrap, 2, 0);
                read_burst(4'(l * 3 + s), start, len, 3'(s), burst_wrap, 1'b0);
            end
        end
        end_test("wrap");

        for (int k = 0; k < 4; k++)
            write_burst(4'($random(seed)), 32'(8 * k), 4'd1, 3'd2, burst_incr, 1,
                        1 + ($random(seed) & 7));
        end_test("bresp");

        read_burst(4'ha, 32'h00, 4'd15, 3'd2, burst_incr, 1'b1);
        read_burst(4'hb, 32'h48, 4'd7, 3'd1, burst_wrap, 1'b1);
        end_test("rstall");

        send_aw(4'hc, 32'h20, 4'd3, 3'd2, burst_incr);
        fork
            begin
                send_wbeats(4'd3, 3'd2, 1);
                take_bresp(0);
            end
            send_aw(4'hd, 32'h50, 4'd3, 3'd2, burst_incr);   // queued behind the first burst
        join
        send_wbeats(4'd3, 3'd2, 0);
        take_bresp(2);
        read_burst(4'he, 32'h20, 4'd15, 3'd2, burst_incr, 1'b1);
        end_test("overlap");

        repeat (4) @(posedge clk);
        $display("checks %0d, check errors %0d, driver failures %0d", checks, errors, drv_fails);
        if (errors == 0 && drv_fails == 0 && checks > 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- flist.f
verilog/axi_slave_pkg.sv
verilog/axi_burst_if.sv
verilog/axi_addr_stage.sv
verilog/axi_write_stage.sv
verilog/axi_read_stage.sv
verilog/axi_byte_mem.sv
verilog/axi_slave_top.sv
dv/axi_checker.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f flist.f \
        --top-module tb_top -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Regression passed" \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
